// ==== source/dram_bridge_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Cache to DRAM bridge definitions
// Widths, burst geometry, controller command codes and shared types.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package dram_bridge_pkg;

  localparam int NUM_CACHE       = 2;
  localparam int LG_NUM_CACHE    = 1;
  localparam int ADDR_WIDTH      = 12;
  localparam int DATA_WIDTH      = 32;
  localparam int BLOCK_WORDS     = 8;
  localparam int BURST_LEN       = 4;
  localparam int NUM_BURST       = BLOCK_WORDS / BURST_LEN;
  localparam int BURST_BYTES     = BURST_LEN * DATA_WIDTH / 8;
  localparam int DRAM_ADDR_WIDTH = ADDR_WIDTH + LG_NUM_CACHE;
  localparam int PKT_WIDTH       = ADDR_WIDTH + 1;
  localparam int PKT_WNR_BIT     = PKT_WIDTH - 1;    // Write-not-read on top.
  localparam int TAG_DEPTH       = 2;

  // Queue and buffer pointer widths.
  localparam int TAG_PTR_WIDTH = $clog2(TAG_DEPTH);
  localparam int TAG_CNT_WIDTH = $clog2(TAG_DEPTH + 1);
  localparam int BUF_PTR_WIDTH = $clog2(BLOCK_WORDS);
  localparam int BUF_CNT_WIDTH = $clog2(BLOCK_WORDS + 1);

  typedef logic [LG_NUM_CACHE-1:0]    cache_id_t;
  typedef logic [ADDR_WIDTH-1:0]      addr_t;
  typedef logic [DRAM_ADDR_WIDTH-1:0] dram_addr_t;
  typedef logic [DATA_WIDTH-1:0]      word_t;
  typedef logic [PKT_WIDTH-1:0]       dma_pkt_t;
  typedef logic [2:0]                 cmd_t;
  typedef logic [$clog2(NUM_BURST)-1:0] burst_cnt_t;
  typedef logic [$clog2(BURST_LEN)-1:0] beat_cnt_t;

  localparam cmd_t CMD_WRITE = 3'd0;
  localparam cmd_t CMD_READ  = 3'd1;

  typedef enum logic {
    REQ_IDLE,
    REQ_SEND
  } req_state_e;

endpackage

`default_nettype wire

// ==== source/dma_arbiter.sv ====
////////////////////////////////////////////////////////////////////////////
// DMA packet arbiter
// Round-robin choice among the caches' valid packets, yumi to the winner.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module dma_arbiter (
  input  logic                                                     clk_i,
  input  logic                                                     reset_i,
  input  dram_bridge_pkg::dma_pkt_t [dram_bridge_pkg::NUM_CACHE-1:0] dma_pkt_i,
  input  logic [dram_bridge_pkg::NUM_CACHE-1:0]                    dma_pkt_v_i,
  output logic [dram_bridge_pkg::NUM_CACHE-1:0]                    dma_pkt_yumi_o,
  output logic                                                     arb_v_o,
  output dram_bridge_pkg::dma_pkt_t                                arb_pkt_o,
  output dram_bridge_pkg::cache_id_t                               arb_tag_o,
  input  logic                                                     arb_yumi_i
);

  dram_bridge_pkg::cache_id_t last_r;      // Last winner.
  dram_bridge_pkg::cache_id_t grant_idx;
  dram_bridge_pkg::cache_id_t cand_idx;
  logic                       grant_found;

  // Search starts just past the last winner.
  always_comb begin
    grant_found = 1'b0;
    grant_idx   = last_r;
    cand_idx    = last_r;
    for (int i = 1; i <= dram_bridge_pkg::NUM_CACHE; i++) begin
      cand_idx = dram_bridge_pkg::cache_id_t'((int'(last_r) + i) % dram_bridge_pkg::NUM_CACHE);
      if (!grant_found && dma_pkt_v_i[cand_idx]) begin
        grant_found = 1'b1;
        grant_idx   = cand_idx;
      end
    end
  end

  assign arb_v_o   = grant_found;
  assign arb_pkt_o = dma_pkt_i[grant_idx];
  assign arb_tag_o = grant_idx;

  always_comb begin
    dma_pkt_yumi_o            = '0;
    dma_pkt_yumi_o[grant_idx] = arb_yumi_i;   // Winner only.
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_r <= dram_bridge_pkg::cache_id_t'(dram_bridge_pkg::NUM_CACHE - 1);
    end else if (arb_yumi_i) begin
      last_r <= grant_idx;
    end
  end

endmodule

`default_nettype wire

// ==== source/dram_req_seq.sv ====
////////////////////////////////////////////////////////////////////////////
// DRAM request sequencer
// Splits a granted block into burst commands toward the controller.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module dram_req_seq (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        arb_v_i,
  input  dram_bridge_pkg::dma_pkt_t   arb_pkt_i,
  input  dram_bridge_pkg::cache_id_t  arb_tag_i,
  output logic                        arb_yumi_o,
  output logic                        app_en_o,
  input  logic                        app_rdy_i,
  output dram_bridge_pkg::cmd_t       app_cmd_o,
  output dram_bridge_pkg::dram_addr_t app_addr_o,
  output logic                        wr_v_o,
  output logic                        rd_v_o,
  output dram_bridge_pkg::cache_id_t  tag_o,
  input  logic                        wr_ready_i,
  input  logic                        rd_ready_i
);

  dram_bridge_pkg::req_state_e req_state_r;
  dram_bridge_pkg::burst_cnt_t burst_cnt_r;
  dram_bridge_pkg::cache_id_t  tag_r;
  dram_bridge_pkg::addr_t      addr_r;
  logic                        wnr_r;
  logic                        path_ready;
  logic                        cmd_acc;
  logic                        last_burst;

  assign arb_yumi_o = (req_state_r == dram_bridge_pkg::REQ_IDLE) & arb_v_i;
  assign path_ready = wnr_r ? wr_ready_i : rd_ready_i;   // Path of this block.
  assign app_en_o   = (req_state_r == dram_bridge_pkg::REQ_SEND) & path_ready;
  assign cmd_acc    = app_en_o & app_rdy_i;
  assign last_burst = (burst_cnt_r == dram_bridge_pkg::burst_cnt_t'(dram_bridge_pkg::NUM_BURST - 1));

  assign app_cmd_o  = wnr_r ? dram_bridge_pkg::CMD_WRITE : dram_bridge_pkg::CMD_READ;
  assign app_addr_o = {tag_r, addr_r};                   // Cache owns a region.
  assign tag_o      = tag_r;
  assign wr_v_o     = cmd_acc & wnr_r;
  assign rd_v_o     = cmd_acc & ~wnr_r;

  ////////////////////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_state_r <= dram_bridge_pkg::REQ_IDLE;
      burst_cnt_r <= '0;
    end else begin
      case (req_state_r)
        dram_bridge_pkg::REQ_IDLE: begin
          if (arb_v_i) begin
            req_state_r <= dram_bridge_pkg::REQ_SEND;
            burst_cnt_r <= '0;
          end
        end
        dram_bridge_pkg::REQ_SEND: begin
          if (cmd_acc) begin
            burst_cnt_r <= burst_cnt_r + 1'b1;
            if (last_burst) begin
              req_state_r <= dram_bridge_pkg::REQ_IDLE;
            end
          end
        end
        default: req_state_r <= dram_bridge_pkg::REQ_IDLE;
      endcase
    end
  end

  // Latched packet fields.
  always_ff @(posedge clk_i) begin
    if (arb_yumi_o) begin
      tag_r  <= arb_tag_i;
      addr_r <= arb_pkt_i[dram_bridge_pkg::ADDR_WIDTH-1:0];
      wnr_r  <= arb_pkt_i[dram_bridge_pkg::PKT_WNR_BIT];
    end else if (cmd_acc) begin
      addr_r <= addr_r + dram_bridge_pkg::addr_t'(dram_bridge_pkg::BURST_BYTES);   // Next burst.
    end
  end

endmodule

`default_nettype wire

// ==== source/dram_wr_path.sv ====
////////////////////////////////////////////////////////////////////////////
// DRAM write path
// Streams the tagged cache's words into the controller write-data port.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module dram_wr_path (
  input  logic                                                  clk_i,
  input  logic                                                  reset_i,
  input  logic                                                  v_i,
  input  dram_bridge_pkg::cache_id_t                            tag_i,
  output logic                                                  ready_o,
  input  dram_bridge_pkg::word_t [dram_bridge_pkg::NUM_CACHE-1:0] dma_data_i,
  input  logic [dram_bridge_pkg::NUM_CACHE-1:0]                 dma_data_v_i,
  output logic [dram_bridge_pkg::NUM_CACHE-1:0]                 dma_data_yumi_o,
  output logic                                                  app_wdf_wren_o,
  input  logic                                                  app_wdf_rdy_i,
  output dram_bridge_pkg::word_t                                app_wdf_data_o,
  output logic                                                  app_wdf_end_o
);

  dram_bridge_pkg::cache_id_t tag_mem [dram_bridge_pkg::TAG_DEPTH];
  logic [dram_bridge_pkg::TAG_PTR_WIDTH-1:0] tag_wptr_r;
  logic [dram_bridge_pkg::TAG_PTR_WIDTH-1:0] tag_rptr_r;
  logic [dram_bridge_pkg::TAG_CNT_WIDTH-1:0] tag_cnt_r;
  dram_bridge_pkg::beat_cnt_t beat_r;
  dram_bridge_pkg::cache_id_t head_tag;
  logic                       head_v;
  logic                       word_acc;
  logic                       tag_pop;

  assign ready_o  = (tag_cnt_r < dram_bridge_pkg::TAG_DEPTH);
  assign head_v   = (tag_cnt_r != '0);
  assign head_tag = tag_mem[tag_rptr_r];

  assign app_wdf_wren_o = head_v & dma_data_v_i[head_tag];
  assign app_wdf_data_o = dma_data_i[head_tag];
  assign app_wdf_end_o  = (beat_r == dram_bridge_pkg::beat_cnt_t'(dram_bridge_pkg::BURST_LEN - 1));
  assign word_acc       = app_wdf_wren_o & app_wdf_rdy_i;
  assign tag_pop        = word_acc & app_wdf_end_o;   // Burst done.

  always_comb begin
    dma_data_yumi_o           = '0;
    dma_data_yumi_o[head_tag] = word_acc;
  end

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      tag_mem[tag_wptr_r] <= tag_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tag_wptr_r <= '0;
      tag_rptr_r <= '0;
      tag_cnt_r  <= '0;
      beat_r     <= '0;
    end else begin
      if (v_i) tag_wptr_r <= tag_wptr_r + 1'b1;
      if (tag_pop) tag_rptr_r <= tag_rptr_r + 1'b1;
      case ({v_i, tag_pop})
        2'b10:   tag_cnt_r <= tag_cnt_r + 1'b1;
        2'b01:   tag_cnt_r <= tag_cnt_r - 1'b1;
        default: tag_cnt_r <= tag_cnt_r;
      endcase
      if (word_acc) beat_r <= tag_pop ? '0 : beat_r + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== source/dram_rd_path.sv ====
////////////////////////////////////////////////////////////////////////////
// DRAM read path
// Buffers returned bursts and hands each word to the requesting cache.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module dram_rd_path (
  input  logic                                                   clk_i,
  input  logic                                                   reset_i,
  input  logic                                                   v_i,
  input  dram_bridge_pkg::cache_id_t                             tag_i,
  output logic                                                   ready_o,
  output dram_bridge_pkg::word_t [dram_bridge_pkg::NUM_CACHE-1:0] dma_data_o,
  output logic [dram_bridge_pkg::NUM_CACHE-1:0]                  dma_data_v_o,
  input  logic [dram_bridge_pkg::NUM_CACHE-1:0]                  dma_data_ready_i,
  input  logic                                                   app_rd_data_valid_i,
  input  dram_bridge_pkg::word_t                                 app_rd_data_i,
  input  logic                                                   app_rd_data_end_i
);

  dram_bridge_pkg::cache_id_t tag_mem [dram_bridge_pkg::TAG_DEPTH];
  dram_bridge_pkg::word_t     buf_mem [dram_bridge_pkg::BLOCK_WORDS];
  logic [dram_bridge_pkg::TAG_PTR_WIDTH-1:0] tag_wptr_r;
  logic [dram_bridge_pkg::TAG_PTR_WIDTH-1:0] tag_rptr_r;
  logic [dram_bridge_pkg::TAG_CNT_WIDTH-1:0] tag_cnt_r;
  logic [dram_bridge_pkg::BUF_PTR_WIDTH-1:0] buf_wptr_r;
  logic [dram_bridge_pkg::BUF_PTR_WIDTH-1:0] buf_rptr_r;
  logic [dram_bridge_pkg::BUF_CNT_WIDTH-1:0] buf_cnt_r;
  dram_bridge_pkg::beat_cnt_t beat_r;
  dram_bridge_pkg::cache_id_t head_tag;
  logic                       out_v;
  logic                       word_take;
  logic                       tag_pop;

  // Room for all outstanding bursts plus the next one.
  assign ready_o = (tag_cnt_r < dram_bridge_pkg::TAG_DEPTH)
                 && ((int'(tag_cnt_r) + 1) * dram_bridge_pkg::BURST_LEN
                     <= dram_bridge_pkg::BLOCK_WORDS);

  assign head_tag  = tag_mem[tag_rptr_r];
  assign out_v     = (tag_cnt_r != '0) & (buf_cnt_r != '0);
  assign word_take = out_v & dma_data_ready_i[head_tag];
  assign tag_pop   = word_take
                   & (beat_r == dram_bridge_pkg::beat_cnt_t'(dram_bridge_pkg::BURST_LEN - 1));

  assign dma_data_o = {dram_bridge_pkg::NUM_CACHE{buf_mem[buf_rptr_r]}};   // Valid steers.

  always_comb begin
    dma_data_v_o           = '0;
    dma_data_v_o[head_tag] = out_v;
  end

  always_ff @(posedge clk_i) begin
    if (v_i) tag_mem[tag_wptr_r] <= tag_i;
    if (app_rd_data_valid_i) buf_mem[buf_wptr_r] <= app_rd_data_i;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tag_wptr_r <= '0;
      tag_rptr_r <= '0;
      tag_cnt_r  <= '0;
      buf_wptr_r <= '0;
      buf_rptr_r <= '0;
      buf_cnt_r  <= '0;
      beat_r     <= '0;
    end else begin
      if (v_i) tag_wptr_r <= tag_wptr_r + 1'b1;
      if (tag_pop) tag_rptr_r <= tag_rptr_r + 1'b1;
      tag_cnt_r <= tag_cnt_r + v_i - tag_pop;
      if (app_rd_data_valid_i) buf_wptr_r <= buf_wptr_r + 1'b1;
      if (word_take) buf_rptr_r <= buf_rptr_r + 1'b1;
      buf_cnt_r <= buf_cnt_r + app_rd_data_valid_i - word_take;
      if (word_take) beat_r <= tag_pop ? '0 : beat_r + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== source/cache_dram_bridge.sv ====
////////////////////////////////////////////////////////////////////////////
// Cache to DRAM controller bridge
// Arbiter, request sequencer and the write and read data paths.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module cache_dram_bridge (
  input  logic                                                    clk_i,
  input  logic                                                    reset_i,
  // Cache side.
  input  dram_bridge_pkg::dma_pkt_t [dram_bridge_pkg::NUM_CACHE-1:0] dma_pkt_i,
  input  logic [dram_bridge_pkg::NUM_CACHE-1:0]                   dma_pkt_v_i,
  output logic [dram_bridge_pkg::NUM_CACHE-1:0]                   dma_pkt_yumi_o,
  output dram_bridge_pkg::word_t [dram_bridge_pkg::NUM_CACHE-1:0]   dma_data_o,
  output logic [dram_bridge_pkg::NUM_CACHE-1:0]                   dma_data_v_o,
  input  logic [dram_bridge_pkg::NUM_CACHE-1:0]                   dma_data_ready_i,
  input  dram_bridge_pkg::word_t [dram_bridge_pkg::NUM_CACHE-1:0]   dma_data_i,
  input  logic [dram_bridge_pkg::NUM_CACHE-1:0]                   dma_data_v_i,
  output logic [dram_bridge_pkg::NUM_CACHE-1:0]                   dma_data_yumi_o,
  // Controller side.
  output logic                                                    app_en_o,
  input  logic                                                    app_rdy_i,
  output dram_bridge_pkg::cmd_t                                   app_cmd_o,
  output dram_bridge_pkg::dram_addr_t                             app_addr_o,
  output logic                                                    app_wdf_wren_o,
  input  logic                                                    app_wdf_rdy_i,
  output dram_bridge_pkg::word_t                                  app_wdf_data_o,
  output logic                                                    app_wdf_end_o,
  input  logic                                                    app_rd_data_valid_i,
  input  dram_bridge_pkg::word_t                                  app_rd_data_i,
  input  logic                                                    app_rd_data_end_i
);

  logic                       arb_v;
  dram_bridge_pkg::dma_pkt_t  arb_pkt;
  dram_bridge_pkg::cache_id_t arb_tag;
  logic                       arb_yumi;
  dram_bridge_pkg::cache_id_t seq_tag;
  logic                       wr_v;
  logic                       wr_ready;
  logic                       rd_v;
  logic                       rd_ready;

  dma_arbiter arb_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .dma_pkt_i      (dma_pkt_i),
    .dma_pkt_v_i    (dma_pkt_v_i),
    .dma_pkt_yumi_o (dma_pkt_yumi_o),
    .arb_v_o        (arb_v),
    .arb_pkt_o      (arb_pkt),
    .arb_tag_o      (arb_tag),
    .arb_yumi_i     (arb_yumi)
  );

  dram_req_seq seq_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .arb_v_i    (arb_v),
    .arb_pkt_i  (arb_pkt),
    .arb_tag_i  (arb_tag),
    .arb_yumi_o (arb_yumi),
    .app_en_o   (app_en_o),
    .app_rdy_i  (app_rdy_i),
    .app_cmd_o  (app_cmd_o),
    .app_addr_o (app_addr_o),
    .wr_v_o     (wr_v),
    .rd_v_o     (rd_v),
    .tag_o      (seq_tag),
    .wr_ready_i (wr_ready),
    .rd_ready_i (rd_ready)
  );

  dram_wr_path wr_i (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .v_i             (wr_v),
    .tag_i           (seq_tag),
    .ready_o         (wr_ready),
    .dma_data_i      (dma_data_i),
    .dma_data_v_i    (dma_data_v_i),
    .dma_data_yumi_o (dma_data_yumi_o),
    .app_wdf_wren_o  (app_wdf_wren_o),
    .app_wdf_rdy_i   (app_wdf_rdy_i),
    .app_wdf_data_o  (app_wdf_data_o),
    .app_wdf_end_o   (app_wdf_end_o)
  );

  dram_rd_path rd_i (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .v_i                 (rd_v),
    .tag_i               (seq_tag),
    .ready_o             (rd_ready),
    .dma_data_o          (dma_data_o),
    .dma_data_v_o        (dma_data_v_o),
    .dma_data_ready_i    (dma_data_ready_i),
    .app_rd_data_valid_i (app_rd_data_valid_i),
    .app_rd_data_i       (app_rd_data_i),
    .app_rd_data_end_i   (app_rd_data_end_i)
  );

endmodule

`default_nettype wire

// ==== test/cache_dram_bridge_props.sv ====
////////////////////////////////////////////////////////////////////////////
// Request sequencer properties
// Enable only outside idle and commands held under controller stall.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module cache_dram_bridge_props (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  dram_bridge_pkg::req_state_e req_state_i,
  input  logic                        arb_yumi_i,
  input  logic                        app_en_i,
  input  logic                        app_rdy_i,
  input  dram_bridge_pkg::cmd_t       app_cmd_i,
  input  dram_bridge_pkg::dram_addr_t app_addr_i
);

  // Enable rises out of idle only after a packet was taken.
  en_after_take: assert property (@(posedge clk_i) disable iff (reset_i)
    (req_state_i == dram_bridge_pkg::REQ_IDLE && !arb_yumi_i) |=> !app_en_i)
    else $error("app_en_o rose out of idle with no packet taken");

  // Stalled command keeps code and address.
  cmd_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (app_en_i && !app_rdy_i) |=> (app_en_i && $stable(app_cmd_i) && $stable(app_addr_i)))
    else $error("command changed before the controller accepted it");

endmodule

bind dram_req_seq cache_dram_bridge_props props_i (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .req_state_i (req_state_r),
  .arb_yumi_i  (arb_yumi_o),
  .app_en_i    (app_en_o),
  .app_rdy_i   (app_rdy_i),
  .app_cmd_i   (app_cmd_o),
  .app_addr_i  (app_addr_o)
);

`default_nettype wire

// ==== test/cache_dram_bridge_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Cache to DRAM bridge testbench
// Random cache traffic against a controller and memory model, with checks.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module cache_dram_bridge_tb;

  localparam int NC               = dram_bridge_pkg::NUM_CACHE;
  localparam int BLOCK_WORDS      = dram_bridge_pkg::BLOCK_WORDS;
  localparam int BURST_LEN        = dram_bridge_pkg::BURST_LEN;
  localparam int WORD_BYTES       = dram_bridge_pkg::DATA_WIDTH / 8;
  localparam int BLOCK_BYTES      = BLOCK_WORDS * WORD_BYTES;
  localparam int BLOCKS_PER_CACHE = 32;
  localparam int TOTAL_BLOCKS     = BLOCKS_PER_CACHE * NC;
  localparam int ST_GAP           = 0;
  localparam int ST_PKT           = 1;
  localparam int ST_WR            = 2;
  localparam int ST_RD            = 3;
  localparam int ST_DONE          = 4;

  logic                               clk_i;
  logic                               reset_i;
  dram_bridge_pkg::dma_pkt_t [NC-1:0] dma_pkt_i;
  logic [NC-1:0]                      dma_pkt_v_i;
  logic [NC-1:0]                      dma_pkt_yumi_o;
  dram_bridge_pkg::word_t [NC-1:0]    dma_data_o;
  logic [NC-1:0]                      dma_data_v_o;
  logic [NC-1:0]                      dma_data_ready_i;
  dram_bridge_pkg::word_t [NC-1:0]    dma_data_i;
  logic [NC-1:0]                      dma_data_v_i;
  logic [NC-1:0]                      dma_data_yumi_o;
  logic                               app_en_o;
  logic                               app_rdy_i;
  dram_bridge_pkg::cmd_t              app_cmd_o;
  dram_bridge_pkg::dram_addr_t        app_addr_o;
  logic                               app_wdf_wren_o;
  logic                               app_wdf_rdy_i;
  dram_bridge_pkg::word_t             app_wdf_data_o;
  logic                               app_wdf_end_o;
  logic                               app_rd_data_valid_i;
  dram_bridge_pkg::word_t             app_rd_data_i;
  logic                               app_rd_data_end_i;

  logic [31:0]                 lcg_state;
  int                          cyc;
  int                          st [NC];
  int                          gap [NC];
  int                          blocks_left [NC];
  int                          idx [NC];
  logic                        blk_wnr [NC];
  dram_bridge_pkg::addr_t      blk_addr [NC];
  dram_bridge_pkg::word_t      blk_words [NC][BLOCK_WORDS];
  dram_bridge_pkg::word_t      ref_mem [int];     // Expected contents.
  dram_bridge_pkg::word_t      dram_mem [int];    // Controller memory.
  dram_bridge_pkg::cmd_t       exp_cmd_q [$];
  int                          exp_addr_q [$];
  dram_bridge_pkg::word_t      exp_wr_q [$];
  int                          wr_cmd_q [$];
  int                          rd_addr_q [$];
  int                          rd_due_q [$];
  int                          wr_beat;
  int                          rd_beat;
  int                          last_win;
  int                          exp_written;
  int                          exp_returned;      // Words sent by the controller.
  int                          written_cnt;
  int                          returned_cnt;

  cache_dram_bridge dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic chance(int pct);
    logic [31:0] r;
    r = next_rand();
    return int'(r[31:16] % 16'd100) < pct;
  endfunction

  // Cache index sits above the block address.
  function automatic int region_addr(int c, dram_bridge_pkg::addr_t a);
    return (c << dram_bridge_pkg::ADDR_WIDTH) + int'(a);
  endfunction

  // First valid cache after the last winner.
  function automatic int rr_winner(int last, logic [NC-1:0] v);
    int w;
    w = -1;
    for (int i = NC; i >= 1; i--) begin
      if (v[(last + i) % NC]) w = (last + i) % NC;
    end
    return w;
  endfunction

  function automatic logic all_done();
    logic done;
    done = (rd_addr_q.size() == 0) && (wr_cmd_q.size() == 0) && (exp_cmd_q.size() == 0);
    for (int c = 0; c < NC; c++) begin
      if (st[c] != ST_DONE) done = 1'b0;
    end
    return done;
  endfunction

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
    $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
    abort_run();
  endtask

  task automatic report_problem(string what);
    $display("ERROR: %s", what);
    abort_run();
  endtask

  task automatic start_block(int c);
    logic [31:0] r;
    r = next_rand();
    blk_wnr[c]  = r[20];
    blk_addr[c] = dram_bridge_pkg::addr_t'(int'(r[26:24]) * BLOCK_BYTES);   // Few blocks reused.
    for (int i = 0; i < BLOCK_WORDS; i++) begin
      blk_words[c][i] = next_rand();
    end
    idx[c] = 0;
    st[c]  = ST_PKT;
  endtask

  task automatic finish_block(int c);
    blocks_left[c]--;
    gap[c] = int'(next_rand() >> 29);
    st[c]  = (blocks_left[c] == 0) ? ST_DONE : ST_GAP;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Transfers taken at the next rising edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic observe();
    int w;
    int a;
    dram_bridge_pkg::word_t exp_word;
    cyc++;
    if (dma_pkt_yumi_o != '0) begin
      assert ($onehot(dma_pkt_yumi_o)) else report_problem("two packet yumis in one cycle");
      w = 0;
      for (int c = 0; c < NC; c++) begin
        if (dma_pkt_yumi_o[c]) w = c;
      end
      assert (st[w] == ST_PKT) else report_problem("packet yumi to a cache with no packet");
      if (last_win >= 0) begin
        assert (w == rr_winner(last_win, dma_pkt_v_i))
          else report_mismatch("round_robin", rr_winner(last_win, dma_pkt_v_i), w);
      end
      last_win = w;
      for (int b = 0; b < dram_bridge_pkg::NUM_BURST; b++) begin
        exp_cmd_q.push_back(blk_wnr[w] ? dram_bridge_pkg::CMD_WRITE : dram_bridge_pkg::CMD_READ);
        exp_addr_q.push_back(region_addr(w, blk_addr[w]) + b * dram_bridge_pkg::BURST_BYTES);
      end
      if (blk_wnr[w]) begin
        for (int i = 0; i < BLOCK_WORDS; i++) begin
          exp_wr_q.push_back(blk_words[w][i]);
          ref_mem[region_addr(w, blk_addr[w]) + i * WORD_BYTES] = blk_words[w][i];
        end
        exp_written += BLOCK_WORDS;
        st[w] = ST_WR;
      end else begin
        st[w] = ST_RD;
      end
    end
    for (int c = 0; c < NC; c++) begin
      if (dma_data_yumi_o[c]) begin
        assert (st[c] == ST_WR) else report_problem("write word taken from an idle cache");
        idx[c]++;
        if (idx[c] == BLOCK_WORDS) finish_block(c);
      end
    end
    if (app_en_o && app_rdy_i) begin
      assert (exp_cmd_q.size() != 0) else report_problem("command issued with no packet taken");
      assert (app_cmd_o == exp_cmd_q[0]) else report_mismatch("app_cmd", exp_cmd_q[0], app_cmd_o);
      assert (int'(app_addr_o) == exp_addr_q[0])
        else report_mismatch("app_addr", exp_addr_q[0], app_addr_o);
      if (app_cmd_o == dram_bridge_pkg::CMD_WRITE) begin
        wr_cmd_q.push_back(int'(app_addr_o));
      end else begin
        rd_addr_q.push_back(int'(app_addr_o));
        rd_due_q.push_back(cyc + 2 + int'(next_rand() >> 16) % 5);   // 2 to 6 cycles.
      end
      void'(exp_cmd_q.pop_front());
      void'(exp_addr_q.pop_front());
    end
    if (app_wdf_wren_o && app_wdf_rdy_i) begin
      assert (wr_cmd_q.size() != 0) else report_problem("write data ahead of its command");
      assert (exp_wr_q.size() != 0) else report_problem("more write words than offered");
      exp_word = exp_wr_q.pop_front();
      assert (app_wdf_data_o == exp_word) else report_mismatch("app_wdf_data", exp_word, app_wdf_data_o);
      assert (app_wdf_end_o == (wr_beat == BURST_LEN - 1))
        else report_mismatch("app_wdf_end", wr_beat == BURST_LEN - 1, app_wdf_end_o);
      dram_mem[wr_cmd_q[0] + wr_beat * WORD_BYTES] = app_wdf_data_o;
      written_cnt++;
      wr_beat++;
      if (wr_beat == BURST_LEN) begin
        wr_beat = 0;
        void'(wr_cmd_q.pop_front());
      end
    end
    for (int c = 0; c < NC; c++) begin
      if (dma_data_v_o[c]) begin
        assert (st[c] == ST_RD) else report_problem("read word offered to a cache that asked for none");
        if (dma_data_ready_i[c]) begin
          a = region_addr(c, blk_addr[c]) + idx[c] * WORD_BYTES;
          exp_word = ref_mem.exists(a) ? ref_mem[a] : dram_bridge_pkg::word_t'(a);
          assert (dma_data_o[c] == exp_word) else report_mismatch("read_data", exp_word, dma_data_o[c]);
          returned_cnt++;
          idx[c]++;
          if (idx[c] == BLOCK_WORDS) finish_block(c);
        end
      end
    end
    for (int c = 0; c < NC; c++) begin
      if (st[c] == ST_GAP) begin
        if (gap[c] == 0) start_block(c);
        else gap[c]--;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Falling edge: new input values
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive();
    int a;
    for (int c = 0; c < NC; c++) begin
      dma_pkt_v_i[c]      = (st[c] == ST_PKT);
      dma_pkt_i[c]        = {blk_wnr[c], blk_addr[c]};
      dma_data_v_i[c]     = (st[c] == ST_WR);
      dma_data_i[c]       = blk_words[c][idx[c] % BLOCK_WORDS];
      dma_data_ready_i[c] = chance(60);
    end
    app_rdy_i           = chance(70);
    app_wdf_rdy_i       = chance(70);
    app_rd_data_valid_i = 1'b0;
    app_rd_data_i       = '0;
    app_rd_data_end_i   = 1'b0;
    if (rd_addr_q.size() != 0 && cyc >= rd_due_q[0]) begin
      a = rd_addr_q[0] + rd_beat * WORD_BYTES;
      app_rd_data_valid_i = 1'b1;
      app_rd_data_i       = dram_mem.exists(a) ? dram_mem[a] : dram_bridge_pkg::word_t'(a);
      app_rd_data_end_i   = (rd_beat == BURST_LEN - 1);   // Fourth word.
      exp_returned++;
      rd_beat++;
      if (rd_beat == BURST_LEN) begin
        rd_beat = 0;
        void'(rd_addr_q.pop_front());
        void'(rd_due_q.pop_front());
      end
    end
  endtask

  initial begin
    lcg_state           = 32'h4e40_0ca1;
    reset_i             = 1'b1;
    dma_pkt_i           = '0;
    dma_pkt_v_i         = '0;
    dma_data_ready_i    = '0;
    dma_data_i          = '0;
    dma_data_v_i        = '0;
    app_rdy_i           = 1'b0;
    app_wdf_rdy_i       = 1'b0;
    app_rd_data_valid_i = 1'b0;
    app_rd_data_i       = '0;
    app_rd_data_end_i   = 1'b0;
    cyc          = 0;
    wr_beat      = 0;
    rd_beat      = 0;
    last_win     = -1;
    exp_written  = 0;
    exp_returned = 0;
    written_cnt  = 0;
    returned_cnt = 0;
    for (int c = 0; c < NC; c++) begin
      st[c]          = ST_GAP;
      gap[c]         = c;
      blocks_left[c] = BLOCKS_PER_CACHE;
      idx[c]         = 0;
      blk_wnr[c]     = 1'b0;
      blk_addr[c]    = '0;
    end
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    assert (!app_en_o && !app_wdf_wren_o && dma_pkt_yumi_o == '0 && dma_data_yumi_o == '0
            && dma_data_v_o == '0)
      else report_problem("DUT outputs not idle after reset");
    while (!all_done()) begin
      drive();
      #1;
      observe();
      @(negedge clk_i);
    end
    assert (written_cnt == exp_written) else report_mismatch("words_written", exp_written, written_cnt);
    assert (returned_cnt == exp_returned)
      else report_mismatch("words_returned", exp_returned, returned_cnt);
    assert (exp_wr_q.size() == 0) else report_problem("offered write words never reached memory");
    $display("Result: PASSED");
    $finish;
  end

  // Generous bound per block.
  initial begin
    repeat (TOTAL_BLOCKS * 200) @(posedge clk_i);
    report_problem("run did not finish within the cycle limit");
  end

endmodule

`default_nettype wire

// ==== all.f ====
source/dram_bridge_pkg.sv
source/dma_arbiter.sv
source/dram_req_seq.sv
source/dram_wr_path.sv
source/dram_rd_path.sv
source/cache_dram_bridge.sv
test/cache_dram_bridge_props.sv
test/cache_dram_bridge_tb.sv

// ==== Makefile ====
# Verilator build and run for the cache to DRAM bridge.

VERILATOR ?= verilator
TOP       ?= cache_dram_bridge_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
